// File: rtl/hazard_pkg.sv
// --------------------------------------------------
// Hazard control shared definitions
// --------------------------------------------------

package hazard_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------

    // Register number width, 32 architectural registers
    localparam int reg_w = 5;

    // Width of each event counter, which wraps on overflow
    localparam int cnt_w = 16;

    // --------------------------------------------------
    // Instruction classes
    // --------------------------------------------------

    // Decoded class of the instruction sitting in ID.
    // The class is all the hazard logic needs to know about which
    // fields are sources and which one is the destination
    typedef enum logic [2:0] {
        // Bubble, reads and writes nothing
        ic_nop    = 3'd0,
        // R-type arithmetic, reads rs and rt, writes rd
        ic_alu    = 3'd1,
        // Load word, reads rs for the address and writes rt
        ic_load   = 3'd2,
        // Store word, reads rs and rt, writes nothing
        ic_store  = 3'd3,
        // beq or bne, compares rs with rt
        ic_branch = 3'd4,
        // Register jump, reads rs only
        ic_jr     = 3'd5,
        // j or jal, no register traffic in this pipeline
        ic_jump   = 3'd6
    } instr_class_t;

    // Code 3'd7 is unused and behaves like a bubble everywhere

endpackage

// File: rtl/pipe_dest_tracker.sv
// --------------------------------------------------
// In-flight destination tracker
// --------------------------------------------------

module pipe_dest_tracker import hazard_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  instr_class_t     id_class,
    input  logic [reg_w-1:0] id_rt,
    input  logic [reg_w-1:0] id_rd,
    input  logic             bubble,
    output logic             id_ex_load,
    output logic             id_ex_branch,
    output logic [reg_w-1:0] id_ex_dest,
    output logic             ex_mem_write,
    output logic [reg_w-1:0] ex_mem_dest,
    output logic             mem_wb_write,
    output logic [reg_w-1:0] mem_wb_dest
);

    // Destination and write flag of the instruction in ID
    logic [reg_w-1:0] id_dest;
    logic             id_is_writer;
    logic             id_writes;

    // Write flag of the ID/EX stage, only needed to feed EX/MEM
    logic             id_ex_write;

    // --------------------------------------------------
    // Decode of the ID instruction
    // --------------------------------------------------

    always_comb begin
        // Loads write rt while ALU ops write rd
        id_dest      = (id_class == ic_load) ? id_rt : id_rd;
        id_is_writer = (id_class == ic_alu) || (id_class == ic_load);
        // A write to r0 is dropped here so no later stage needs an r0 check
        id_writes    = id_is_writer && (id_dest != '0);
    end

    // --------------------------------------------------
    // Stage flags
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex_write  <= 1'b0;
            id_ex_load   <= 1'b0;
            id_ex_branch <= 1'b0;
            ex_mem_write <= 1'b0;
            mem_wb_write <= 1'b0;
        end else begin
            // A bubble enters ID/EX in place of the ID instruction on a stall or flush
            id_ex_write  <= id_writes && !bubble;
            // The load flag marks only loads that really write a register
            id_ex_load   <= id_writes && (id_class == ic_load) && !bubble;
            id_ex_branch <= (id_class == ic_branch) && !bubble;
            // Later stages simply shift
            ex_mem_write <= id_ex_write;
            mem_wb_write <= ex_mem_write;
        end
    end

    // --------------------------------------------------
    // Stage destinations
    // --------------------------------------------------

    // Register numbers are only meaningful next to a set flag
    always_ff @(posedge clk) begin
        id_ex_dest  <= id_dest;
        ex_mem_dest <= id_ex_dest;
        mem_wb_dest <= ex_mem_dest;
    end

endmodule

// File: rtl/stall_detector.sv
// --------------------------------------------------
// Stall cause detection
// --------------------------------------------------

module stall_detector import hazard_pkg::*; (
    input  instr_class_t     id_class,
    input  logic [reg_w-1:0] id_rs,
    input  logic [reg_w-1:0] id_rt,
    input  logic             id_ex_load,
    input  logic [reg_w-1:0] id_ex_dest,
    input  logic             ex_mem_write,
    input  logic [reg_w-1:0] ex_mem_dest,
    input  logic             mem_wb_write,
    input  logic [reg_w-1:0] mem_wb_dest,
    output logic             load_use,
    output logic             branch_dep,
    output logic             jr_dep
);

    // Which source fields the ID instruction really reads
    logic uses_rs;
    logic uses_rt;

    // Matches against the writing instructions further down the pipe
    logic dep_exmem_rs;
    logic dep_exmem_rt;
    logic dep_memwb_rs;
    logic dep_memwb_rt;

    always_comb begin
        // rs is an operand of everything except a bubble or a jump
        uses_rs = (id_class == ic_alu) || (id_class == ic_load) ||
                  (id_class == ic_store) || (id_class == ic_branch) ||
                  (id_class == ic_jr);
        // For a load rt is the destination, so it does not count
        uses_rt = (id_class == ic_alu) || (id_class == ic_store) ||
                  (id_class == ic_branch);
    end

    // The tracker already cleared any write to r0
    always_comb begin
        dep_exmem_rs = ex_mem_write && (ex_mem_dest == id_rs);
        dep_exmem_rt = ex_mem_write && (ex_mem_dest == id_rt);
        dep_memwb_rs = mem_wb_write && (mem_wb_dest == id_rs);
        dep_memwb_rt = mem_wb_write && (mem_wb_dest == id_rt);
    end

    always_comb begin
        // Classic load-use case, the loaded value is not ready for EX
        load_use   = id_ex_load &&
                     ((uses_rs && (id_ex_dest == id_rs)) ||
                      (uses_rt && (id_ex_dest == id_rt)));
        // Branches compare in ID and need both operands written back
        branch_dep = (id_class == ic_branch) &&
                     (dep_exmem_rs || dep_exmem_rt || dep_memwb_rs || dep_memwb_rt);
        // jr only waits on rs
        jr_dep     = (id_class == ic_jr) && (dep_exmem_rs || dep_memwb_rs);
    end

endmodule

// File: rtl/redirect_detector.sv
// --------------------------------------------------
// Redirect detection
// --------------------------------------------------

module redirect_detector import hazard_pkg::*; (
    input  instr_class_t id_class,
    input  logic         ex_branch_taken,
    input  logic         id_ex_branch,
    output logic         branch_redirect,
    output logic         jump_redirect
);

    // --------------------------------------------------
    // Taken branch resolved in EX
    // --------------------------------------------------

    // The taken strobe only counts when a branch really sits in EX.
    // A stray strobe next to a bubble or an ALU op is ignored
    always_comb begin
        branch_redirect = ex_branch_taken && id_ex_branch;
    end

    // --------------------------------------------------
    // Unconditional jump in ID
    // --------------------------------------------------

    // j and jal resolve in ID, so only the fetch behind them is wrong-path
    always_comb begin
        jump_redirect = (id_class == ic_jump);
    end

endmodule

// File: rtl/hazard_arbiter.sv
// --------------------------------------------------
// Hazard priority and event counters
// --------------------------------------------------

module hazard_arbiter import hazard_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             load_use,
    input  logic             branch_dep,
    input  logic             jr_dep,
    input  logic             branch_redirect,
    input  logic             jump_redirect,
    output logic             pc_write,
    output logic             if_id_write,
    output logic             control_mux_sel,
    output logic             if_flush,
    output logic             id_flush,
    output logic             bubble,
    output logic [cnt_w-1:0] stall_cycles,
    output logic [cnt_w-1:0] redirect_count
);

    logic any_redirect;
    logic any_stall;
    // High when a stall cause is present and no redirect overrides it
    logic stall_win;

    always_comb begin
        any_redirect = branch_redirect || jump_redirect;
        any_stall    = load_use || branch_dep || jr_dep;
        stall_win    = any_stall && !any_redirect;
    end

    // --------------------------------------------------
    // Pipeline controls
    // --------------------------------------------------

    always_comb begin
        // A redirect wins, otherwise the stalled instruction would hold the
        // wrong-path fetch forever
        if_flush        = any_redirect;
        // Only a branch from EX kills the instruction already in ID
        id_flush        = branch_redirect;
        // Hold PC and IF/ID and send zero controls into ID/EX on a stall
        pc_write        = !stall_win;
        if_id_write     = !stall_win;
        control_mux_sel = !stall_win;
        // ID/EX receives nothing useful on a stall or when ID is flushed
        bubble          = stall_win || branch_redirect;
    end

    // --------------------------------------------------
    // Event counters
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_cycles   <= '0;
            redirect_count <= '0;
        end else begin
            if (stall_win)
                stall_cycles <= stall_cycles + 1'b1;
            if (any_redirect)
                redirect_count <= redirect_count + 1'b1;
        end
    end

endmodule

// File: rtl/hazard_unit_top.sv
// --------------------------------------------------
// Hazard control unit
// --------------------------------------------------

module hazard_unit_top import hazard_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  instr_class_t     id_class,
    input  logic [reg_w-1:0] id_rs,
    input  logic [reg_w-1:0] id_rt,
    input  logic [reg_w-1:0] id_rd,
    input  logic             ex_branch_taken,
    output logic             pc_write,
    output logic             if_id_write,
    output logic             control_mux_sel,
    output logic             if_flush,
    output logic             id_flush,
    output logic [cnt_w-1:0] stall_cycles,
    output logic [cnt_w-1:0] redirect_count
);

    // Tracker state seen by the detectors
    logic             id_ex_load;
    logic             id_ex_branch;
    logic [reg_w-1:0] id_ex_dest;
    logic             ex_mem_write;
    logic [reg_w-1:0] ex_mem_dest;
    logic             mem_wb_write;
    logic [reg_w-1:0] mem_wb_dest;

    // Detector results and the bubble fed back to the tracker
    logic load_use;
    logic branch_dep;
    logic jr_dep;
    logic branch_redirect;
    logic jump_redirect;
    logic bubble;

    pipe_dest_tracker pipe_dest_tracker_inst (
        .clk          (clk),
        .rst          (rst),
        .id_class     (id_class),
        .id_rt        (id_rt),
        .id_rd        (id_rd),
        .bubble       (bubble),
        .id_ex_load   (id_ex_load),
        .id_ex_branch (id_ex_branch),
        .id_ex_dest   (id_ex_dest),
        .ex_mem_write (ex_mem_write),
        .ex_mem_dest  (ex_mem_dest),
        .mem_wb_write (mem_wb_write),
        .mem_wb_dest  (mem_wb_dest)
    );

    stall_detector stall_detector_inst (
        .id_class     (id_class),
        .id_rs        (id_rs),
        .id_rt        (id_rt),
        .id_ex_load   (id_ex_load),
        .id_ex_dest   (id_ex_dest),
        .ex_mem_write (ex_mem_write),
        .ex_mem_dest  (ex_mem_dest),
        .mem_wb_write (mem_wb_write),
        .mem_wb_dest  (mem_wb_dest),
        .load_use     (load_use),
        .branch_dep   (branch_dep),
        .jr_dep       (jr_dep)
    );

    redirect_detector redirect_detector_inst (
        .id_class        (id_class),
        .ex_branch_taken (ex_branch_taken),
        .id_ex_branch    (id_ex_branch),
        .branch_redirect (branch_redirect),
        .jump_redirect   (jump_redirect)
    );

    hazard_arbiter hazard_arbiter_inst (
        .clk             (clk),
        .rst             (rst),
        .load_use        (load_use),
        .branch_dep      (branch_dep),
        .jr_dep          (jr_dep),
        .branch_redirect (branch_redirect),
        .jump_redirect   (jump_redirect),
        .pc_write        (pc_write),
        .if_id_write     (if_id_write),
        .control_mux_sel (control_mux_sel),
        .if_flush        (if_flush),
        .id_flush        (id_flush),
        .bubble          (bubble),
        .stall_cycles    (stall_cycles),
        .redirect_count  (redirect_count)
    );

endmodule

// File: verification/hazard_model.sv
// --------------------------------------------------
// Hazard control reference model
// --------------------------------------------------

module hazard_model import hazard_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  instr_class_t     id_class,
    input  logic [reg_w-1:0] id_rs,
    input  logic [reg_w-1:0] id_rt,
    input  logic [reg_w-1:0] id_rd,
    input  logic             ex_branch_taken,
    output logic             pc_write,
    output logic             if_id_write,
    output logic             control_mux_sel,
    output logic             if_flush,
    output logic             id_flush,
    output logic [cnt_w-1:0] stall_cycles,
    output logic [cnt_w-1:0] redirect_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // Index 0 is ID/EX, 1 is EX/MEM and 2 is MEM/WB
    logic             wr [3];
    logic [reg_w-1:0] dst [3];
    logic             ex_is_load;
    logic             ex_is_branch;
    logic [reg_w-1:0] new_dst;
    logic             new_wr;
    logic             stall;
    logic             redirect;
    logic             kill;

    // True when a stage holds a real write to register r
    function automatic logic hit(input int stage, input logic [reg_w-1:0] r);
        return wr[stage] && (dst[stage] == r);
    endfunction

    always_comb begin
        logic rd_rs;
        logic rd_rt;
        logic lu;
        logic dep;
        rd_rs    = id_class inside {ic_alu, ic_load, ic_store, ic_branch, ic_jr};
        rd_rt    = id_class inside {ic_alu, ic_store, ic_branch};
        new_dst  = (id_class == ic_load) ? id_rt : id_rd;
        new_wr   = (id_class inside {ic_alu, ic_load}) && (new_dst != 0);
        lu       = ex_is_load && ((rd_rs && hit(0, id_rs)) || (rd_rt && hit(0, id_rt)));
        // Branches wait on both operands, jr only on rs
        dep      = (id_class == ic_branch) &&
                   (hit(1, id_rs) || hit(1, id_rt) || hit(2, id_rs) || hit(2, id_rt));
        dep      = dep || ((id_class == ic_jr) && (hit(1, id_rs) || hit(2, id_rs)));
        kill     = ex_branch_taken && ex_is_branch;
        redirect = kill || (id_class == ic_jump);
        stall    = (lu || dep) && !redirect;
        pc_write        = !stall;
        if_id_write     = !stall;
        control_mux_sel = !stall;
        if_flush        = redirect;
        id_flush        = kill;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr             <= '{1'b0, 1'b0, 1'b0};
            ex_is_load     <= 1'b0;
            ex_is_branch   <= 1'b0;
            stall_cycles   <= '0;
            redirect_count <= '0;
        end else begin
            // Stalled or flushed instructions never enter EX
            wr[0]        <= new_wr && !(stall || kill);
            ex_is_load   <= (id_class == ic_load) && !(stall || kill);
            ex_is_branch <= (id_class == ic_branch) && !(stall || kill);
            wr[1]        <= wr[0];
            wr[2]        <= wr[1];
            stall_cycles   <= stall_cycles + cnt_w'(stall);
            redirect_count <= redirect_count + cnt_w'(redirect);
        end
        dst[0] <= new_dst;
        dst[1] <= dst[0];
        dst[2] <= dst[1];
    end

endmodule

// File: verification/hazard_tb.sv
// --------------------------------------------------
// Hazard control unit testbench
// --------------------------------------------------

module hazard_tb import hazard_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    // Random stream length and a bound of six cycles per instruction
    localparam int n_random   = 2000;
    localparam int max_cycles = 2 * (n_random * 6 + 100);

    logic             clk;
    logic             rst;
    instr_class_t     id_class;
    logic [reg_w-1:0] id_rs;
    logic [reg_w-1:0] id_rt;
    logic [reg_w-1:0] id_rd;
    logic             ex_branch_taken;
    logic             pc_write;
    logic             if_id_write;
    logic             control_mux_sel;
    logic             if_flush;
    logic             id_flush;
    logic [cnt_w-1:0] stall_cycles;
    logic [cnt_w-1:0] redirect_count;
    logic             exp_pc_write;
    logic             exp_if_id_write;
    logic             exp_control_mux_sel;
    logic             exp_if_flush;
    logic             exp_id_flush;
    logic [cnt_w-1:0] exp_stall_cycles;
    logic [cnt_w-1:0] exp_redirect_count;

    integer seed;
    int     error_count;
    int     tests_passed;
    int     tests_failed;
    int     cycle_count;
    int     held;
    int     errs_at_start;

    hazard_unit_top hazard_unit_top_inst (.*);

    hazard_model hazard_model_inst (
        .clk, .rst, .id_class, .id_rs, .id_rt, .id_rd, .ex_branch_taken,
        .pc_write        (exp_pc_write),
        .if_id_write     (exp_if_id_write),
        .control_mux_sel (exp_control_mux_sel),
        .if_flush        (exp_if_flush),
        .id_flush        (exp_id_flush),
        .stall_cycles    (exp_stall_cycles),
        .redirect_count  (exp_redirect_count)
    );

    always #2 clk = ~clk;

    // Ends a run that stops making progress
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > max_cycles) begin
            $display("Timeout: the run did not end within %0d cycles", max_cycles);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_val(input string name, input int got, input int want);
        if (got != want) begin
            $display("ERROR %0t: %s is %0d, expected %0d", $time, name, got, want);
            error_count++;
        end
    endtask

    task automatic compare_outputs();
        check_val("pc_write", pc_write, exp_pc_write);
        check_val("if_id_write", if_id_write, exp_if_id_write);
        check_val("control_mux_sel", control_mux_sel, exp_control_mux_sel);
        check_val("if_flush", if_flush, exp_if_flush);
        check_val("id_flush", id_flush, exp_id_flush);
        check_val("stall_cycles", stall_cycles, exp_stall_cycles);
        check_val("redirect_count", redirect_count, exp_redirect_count);
    endtask

    // One cycle of ID input, compared with the model at the falling edge
    task automatic drive(input instr_class_t cls, input logic [reg_w-1:0] rs,
                         input logic [reg_w-1:0] rt, input logic [reg_w-1:0] rd,
                         input logic taken);
        @(posedge clk);
        #0.5;
        id_class        = cls;
        id_rs           = rs;
        id_rt           = rt;
        id_rd           = rd;
        ex_branch_taken = taken;
        @(negedge clk);
        compare_outputs();
    endtask

    // Presents one instruction until it leaves ID and reports the stall cycles
    task automatic issue(input instr_class_t cls, input logic [reg_w-1:0] rs,
                         input logic [reg_w-1:0] rt, input logic [reg_w-1:0] rd,
                         input logic taken, output int stalls);
        stalls = 0;
        drive(cls, rs, rt, rd, taken);
        while (!if_id_write) begin
            stalls++;
            drive(cls, rs, rt, rd, 1'b0);
        end
        // A killed fetch shows up in ID as a bubble
        while (if_flush)
            drive(ic_nop, 0, 0, 0, 1'b0);
    endtask

    task automatic drain();
        repeat (3) drive(ic_nop, 0, 0, 0, 1'b0);
    endtask

    task automatic end_test(input string name);
        if (error_count == errs_at_start) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("FAIL %s with %0d errors", name, error_count - errs_at_start);
            tests_failed++;
        end
        errs_at_start = error_count;
    endtask

    // Loads and branches dominate so that dependencies show up often
    function automatic instr_class_t pick_class(input int r);
        if (r < 4) return ic_load;
        if (r < 7) return ic_branch;
        if (r < 10) return ic_alu;
        if (r < 11) return ic_store;
        if (r < 12) return ic_jr;
        if (r < 13) return ic_jump;
        return ic_nop;
    endfunction

    initial begin
        seed = 32'hf57b_9873;
        clk = 1'b0;
        rst = 1'b1;
        id_class = ic_nop;
        id_rs = '0;
        id_rt = '0;
        id_rd = '0;
        ex_branch_taken = 1'b0;
        error_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count = 0;
        errs_at_start = 0;
        repeat (3) @(posedge clk);
        #0.5;
        rst = 1'b0;

        // --------------------------------------------------
        // Directed cases
        // --------------------------------------------------

        drive(ic_nop, 0, 0, 0, 1'b0);
        check_val("pc_write after reset", pc_write, 1);
        check_val("if_id_write after reset", if_id_write, 1);
        check_val("control_mux_sel after reset", control_mux_sel, 1);
        check_val("if_flush after reset", if_flush, 0);
        check_val("id_flush after reset", id_flush, 0);
        check_val("stall_cycles after reset", stall_cycles, 0);
        check_val("redirect_count after reset", redirect_count, 0);
        end_test("reset state");

        issue(ic_load, 1, 2, 0, 1'b0, held);
        issue(ic_alu, 2, 3, 1, 1'b0, held);
        check_val("load-use stall cycles", held, 1);
        issue(ic_load, 1, 0, 0, 1'b0, held);
        issue(ic_alu, 0, 3, 1, 1'b0, held);
        check_val("r0 load stall cycles", held, 0);
        end_test("load-use");

        // A load right ahead holds the branch through ID/EX, EX/MEM and MEM/WB
        drain();
        issue(ic_load, 1, 3, 0, 1'b0, held);
        issue(ic_branch, 3, 2, 0, 1'b0, held);
        check_val("branch after load stall cycles", held, 3);
        drain();
        issue(ic_alu, 1, 1, 3, 1'b0, held);
        issue(ic_nop, 0, 0, 0, 1'b0, held);
        issue(ic_branch, 2, 3, 0, 1'b0, held);
        check_val("branch two behind stall cycles", held, 2);
        drain();
        issue(ic_alu, 1, 1, 3, 1'b0, held);
        issue(ic_nop, 0, 0, 0, 1'b0, held);
        issue(ic_jr, 1, 3, 0, 1'b0, held);
        check_val("jr on rt stall cycles", held, 0);
        end_test("branch and jr operands");

        drain();
        issue(ic_alu, 1, 1, 2, 1'b0, held);
        issue(ic_branch, 5, 6, 0, 1'b0, held);
        drive(ic_branch, 2, 0, 0, 1'b1);
        check_val("if_flush on taken branch", if_flush, 1);
        check_val("id_flush on taken branch", id_flush, 1);
        check_val("pc_write on taken branch", pc_write, 1);
        check_val("if_id_write on taken branch", if_id_write, 1);
        drive(ic_nop, 0, 0, 0, 1'b0);
        drive(ic_jump, 0, 0, 0, 1'b0);
        check_val("if_flush on jump", if_flush, 1);
        check_val("id_flush on jump", id_flush, 0);
        drive(ic_nop, 0, 0, 0, 1'b0);
        drive(ic_nop, 0, 0, 0, 1'b1);
        check_val("if_flush on stray strobe", if_flush, 0);
        check_val("id_flush on stray strobe", id_flush, 0);
        end_test("redirect priority");

        // --------------------------------------------------
        // Random stream and final counts
        // --------------------------------------------------

        for (int i = 0; i < n_random; i++) begin
            issue(pick_class($random(seed) & 15), $random(seed) & 3, $random(seed) & 3,
                  $random(seed) & 3, $random(seed) & 1, held);
        end
        end_test("random stream");

        check_val("final stall_cycles", stall_cycles, exp_stall_cycles);
        check_val("final redirect_count", redirect_count, exp_redirect_count);
        end_test("event counters");

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: verilog.f
rtl/hazard_pkg.sv
rtl/pipe_dest_tracker.sv
rtl/stall_detector.sv
rtl/redirect_detector.sv
rtl/hazard_arbiter.sv
rtl/hazard_unit_top.sv
verification/hazard_model.sv
verification/hazard_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the hazard unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
        --top-module hazard_tb -f verilog.f -o hazard_sim > build.log 2>&1; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/hazard_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation did not exit cleanly"
    exit 1
fi

cat sim.log
if grep -q "All tests passed!" sim.log; then
    exit 0
fi
exit 1
